// ==== compile.f ====
+incdir+design
design/wb_pkg.sv
design/wb_writeback.sv
design/wb_csr_file.sv
design/wb_gpr_file.sv
design/wb_top.sv
tb/wb_checker.sv
tb/tb_wb_top.sv

// ==== design/wb_csr_file.sv ====
/*
 * Machine CSR file
 * Holds mscratch, mepc, mcause and mtvec; software access and trap capture
 */
`timescale 1ns/1ns
`include "wb_macros.svh"

module wb_csr_file (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_pkg::wb_csr_req_s     csr_req,
    input  wb_pkg::wb_trap_s        trap,
    output logic [`WB_XLEN-1:0]     csr_rdata,  // Old value at csr_req.addr
    output logic [`WB_XLEN-1:0]     csr_mepc,
    output logic [`WB_XLEN-1:0]     csr_mtvec
);

    logic [`WB_XLEN-1:0] mscratch;
    logic [`WB_XLEN-1:0] mepc;
    logic [`WB_XLEN-1:0] mcause;
    logic [`WB_XLEN-1:0] mtvec;
    logic [`WB_XLEN-1:0] new_val;   // Value after write, set or clear
    logic                sw_we;

    // ------------------------------------------------------------------------
    // Read decode

    always_comb begin
        case (csr_req.addr)
            `WB_CSR_MSCRATCH: csr_rdata = mscratch;
            `WB_CSR_MEPC:     csr_rdata = mepc;
            `WB_CSR_MCAUSE:   csr_rdata = mcause;
            `WB_CSR_MTVEC:    csr_rdata = mtvec;
            default:          csr_rdata = '0;   // Unimplemented reads zero
        endcase
    end

    // ------------------------------------------------------------------------
    // Software update

    always_comb begin
        if (csr_req.wr) begin
            new_val = csr_req.wdata;
        end else if (csr_req.set) begin
            new_val = csr_rdata | csr_req.wdata;
        end else begin
            new_val = csr_rdata & ~csr_req.wdata;   // Clear
        end
    end

    assign sw_we = csr_req.en && (csr_req.wr || csr_req.set || csr_req.clr);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtvec    <= '0;
        end else if (trap.valid) begin
            mepc   <= trap.pc;                      // Trap capture first
            mcause <= {trap.intr, {(`WB_XLEN-7){1'b0}}, trap.cause};
        end else if (sw_we) begin
            case (csr_req.addr)
                `WB_CSR_MSCRATCH: mscratch <= new_val;
                `WB_CSR_MEPC:     mepc     <= new_val;
                `WB_CSR_MCAUSE:   mcause   <= new_val;
                `WB_CSR_MTVEC:    mtvec    <= new_val;
                default:          ;                 // Write ignored
            endcase
        end
    end

    assign csr_mepc  = mepc;
    assign csr_mtvec = mtvec;

endmodule

// ==== design/wb_gpr_file.sv ====
/*
 * General purpose register file
 * 32 x 32 bits, x0 reads zero, one write port and one debug read port
 */
`timescale 1ns/1ns
`include "wb_macros.svh"

module wb_gpr_file (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_pkg::wb_gpr_wr_s      gpr_wr,
    input  logic [4:0]              dbg_rs,
    output logic [`WB_XLEN-1:0]     dbg_rdata
);

    logic [`WB_XLEN-1:0] regs [1:31];   // No storage for x0

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_wr.wen && gpr_wr.rd != 5'd0) begin
            regs[gpr_wr.rd] <= gpr_wr.wdata;    // x0 writes dropped
        end
    end

    // Combinational observation port
    always_comb begin
        if (dbg_rs == 5'd0) begin
            dbg_rdata = '0;
        end else begin
            dbg_rdata = regs[dbg_rs];
        end
    end

endmodule

// ==== design/wb_macros.svh ====
/*
 * Writeback stage constants
 * Data width, functional-unit bits, micro-op codes, trap causes, CSR addresses
 */
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

`define WB_XLEN         32          // Fixed data width

// ------------------------------------------------------------------------
// One-hot functional unit field
`define WB_FU_ALU       0
`define WB_FU_MUL       1
`define WB_FU_LSU       2
`define WB_FU_CFU       3
`define WB_FU_CSR       4

// ------------------------------------------------------------------------
// Control flow micro-op codes
`define WB_CFU_TAKEN    5'd1        // Taken conditional branch
`define WB_CFU_JALI     5'd2        // Jump and link, immediate
`define WB_CFU_JALR     5'd3        // Jump and link, register
`define WB_CFU_EBREAK   5'd4
`define WB_CFU_ECALL    5'd5
`define WB_CFU_MRET     5'd6

`define WB_LSU_LOAD     0           // Micro-op bit marking a load

// Machine trap causes
`define WB_TRAP_BREAKPT 6'd3
`define WB_TRAP_ECALLM  6'd11

// Machine CSR addresses
`define WB_CSR_MSCRATCH 12'h340
`define WB_CSR_MEPC     12'h341
`define WB_CSR_MCAUSE   12'h342
`define WB_CSR_MTVEC    12'h305

`endif

// ==== design/wb_pkg.sv ====
/*
 * Writeback stage types
 * Stage payload, register write, CSR request, trap and trace records
 */
`include "wb_macros.svh"

package wb_pkg;

    // CSR view of the micro-op word
    typedef struct packed {
        logic spare;                        // Unused by the CSR unit
        logic clr;                          // Clear bits given by wdata
        logic set;                          // Set bits given by wdata
        logic write;                        // Plain write
        logic read;                         // Old value goes to rd
    } wb_uop_csr_s;

    // Micro-op word, flags for CSR and a code for control flow
    typedef union packed {
        wb_uop_csr_s csr;
        logic [4:0]  cfu;
    } wb_uop_u;

    // Stage 4 payload
    typedef struct packed {
        logic [4:0]             rd;         // Destination register
        logic [`WB_XLEN-1:0]    opr_a;      // Result or jump target
        logic [`WB_XLEN-1:0]    opr_b;      // CSR address in low bits
        logic [`WB_XLEN-1:0]    pc;
        logic [`WB_XLEN-1:0]    next_pc;    // Link value for jumps
        wb_uop_u                uop;
        logic [4:0]             fu;         // One-hot unit select
        logic                   trap;       // Externally raised trap
        logic [31:0]            instr;
    } wb_stage_s;

    typedef struct packed {
        logic                   wen;
        logic [4:0]             rd;
        logic [`WB_XLEN-1:0]    wdata;
    } wb_gpr_wr_s;

    typedef struct packed {
        logic                   en;         // One cycle per access
        logic                   wr;
        logic                   set;
        logic                   clr;
        logic [11:0]            addr;
        logic [`WB_XLEN-1:0]    wdata;
    } wb_csr_req_s;

    typedef struct packed {
        logic                   valid;      // Capture strobe for mepc/mcause
        logic                   cpu;        // Raised by ECALL or EBREAK
        logic                   intr;       // Raised from outside the core
        logic [5:0]             cause;
        logic [`WB_XLEN-1:0]    pc;
    } wb_trap_s;

    typedef struct packed {
        logic                   valid;
        logic [`WB_XLEN-1:0]    pc;
        logic [31:0]            instr;
    } wb_trace_s;

endpackage

// ==== design/wb_top.sv ====
/*
 * Writeback stage top level
 * Connects the writeback logic to the CSR file and the GPR file
 */
`timescale 1ns/1ns
`include "wb_macros.svh"

module wb_top (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_pkg::wb_stage_s       stage,
    input  logic                    s4_valid,
    output logic                    s4_busy,
    output logic                    cf_req,
    output logic [`WB_XLEN-1:0]     cf_target,
    input  logic                    cf_ack,
    output wb_pkg::wb_gpr_wr_s      fwd,        // Also the GPR write
    output logic                    fwd_csr,
    output wb_pkg::wb_trace_s       trace,
    input  logic [4:0]              dbg_rs,
    output logic [`WB_XLEN-1:0]     dbg_rdata
);

    wb_pkg::wb_csr_req_s    csr_req;
    wb_pkg::wb_trap_s       trap;
    logic [`WB_XLEN-1:0]    csr_rdata;
    logic [`WB_XLEN-1:0]    csr_mepc;
    logic [`WB_XLEN-1:0]    csr_mtvec;

    // ------------------------------------------------------------------------
    // Stage logic
    wb_writeback u_writeback (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .stage     (stage),
        .s4_valid  (s4_valid),
        .s4_busy   (s4_busy),
        .gpr_wr    (fwd),
        .fwd_csr   (fwd_csr),
        .csr_req   (csr_req),
        .csr_rdata (csr_rdata),
        .csr_mepc  (csr_mepc),
        .csr_mtvec (csr_mtvec),
        .trap      (trap),
        .trace     (trace),
        .cf_req    (cf_req),
        .cf_target (cf_target),
        .cf_ack    (cf_ack)
    );

    // ------------------------------------------------------------------------
    // State
    wb_csr_file u_csr_file (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .csr_req   (csr_req),
        .trap      (trap),
        .csr_rdata (csr_rdata),
        .csr_mepc  (csr_mepc),
        .csr_mtvec (csr_mtvec)
    );

    wb_gpr_file u_gpr_file (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .gpr_wr    (fwd),
        .dbg_rs    (dbg_rs),
        .dbg_rdata (dbg_rdata)
    );

endmodule

// ==== design/wb_writeback.sv ====
/*
 * Writeback stage
 * Finishes each stage 4 instruction: GPR write, CSR access, control flow
 * changes, trap reporting and instruction trace
 */
`timescale 1ns/1ns
`include "wb_macros.svh"

module wb_writeback (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_pkg::wb_stage_s       stage,      // Stage 4 payload
    input  logic                    s4_valid,
    output logic                    s4_busy,
    output wb_pkg::wb_gpr_wr_s      gpr_wr,
    output logic                    fwd_csr,    // CSR op sits in stage 4
    output wb_pkg::wb_csr_req_s     csr_req,
    input  logic [`WB_XLEN-1:0]     csr_rdata,
    input  logic [`WB_XLEN-1:0]     csr_mepc,
    input  logic [`WB_XLEN-1:0]     csr_mtvec,
    output wb_pkg::wb_trap_s        trap,
    output wb_pkg::wb_trace_s       trace,
    output logic                    cf_req,
    output logic [`WB_XLEN-1:0]     cf_target,
    input  logic                    cf_ack
);

    logic   pipe_progress;          // Instruction retires this cycle
    logic   fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic   csr_done;               // CSR access already issued
    logic   csr_gpr_wen;
    logic   cfu_taken, cfu_link, cfu_ebreak, cfu_ecall, cfu_mret;
    logic   cfu_trap;               // ECALL or EBREAK
    logic   cf_tgt_trap;            // Request goes to mtvec
    logic   cf_pending;             // Stage needs a control flow change
    logic   cfu_done;               // Request acked, stage still stalled
    logic   cf_finish_now;
    logic   load_wen;

    // ------------------------------------------------------------------------
    // Decode

    assign fu_alu = s4_valid && stage.fu[`WB_FU_ALU];
    assign fu_mul = s4_valid && stage.fu[`WB_FU_MUL];
    assign fu_lsu = s4_valid && stage.fu[`WB_FU_LSU];
    assign fu_cfu = s4_valid && stage.fu[`WB_FU_CFU];
    assign fu_csr = s4_valid && stage.fu[`WB_FU_CSR];

    assign pipe_progress = s4_valid && !s4_busy;
    assign load_wen      = fu_lsu && stage.uop.cfu[`WB_LSU_LOAD];  // Stores write nothing

    // ------------------------------------------------------------------------
    // CSR access

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            csr_done <= 1'b0;
        end else begin
            csr_done <= !pipe_progress && (csr_done || csr_req.en);  // Held across stalls
        end
    end

    assign csr_req.en    = fu_csr && !csr_done;
    assign csr_req.wr    = fu_csr && stage.uop.csr.write;
    assign csr_req.set   = fu_csr && stage.uop.csr.set;
    assign csr_req.clr   = fu_csr && stage.uop.csr.clr;
    assign csr_req.addr  = stage.opr_b[11:0];
    assign csr_req.wdata = stage.opr_a;

    assign csr_gpr_wen = csr_req.en && stage.uop.csr.read;   // Old value, first cycle only

    // ------------------------------------------------------------------------
    // Control flow

    assign cfu_taken  = fu_cfu && (stage.uop.cfu == `WB_CFU_TAKEN ||
                                   stage.uop.cfu == `WB_CFU_JALI  ||
                                   stage.uop.cfu == `WB_CFU_JALR);
    assign cfu_link   = fu_cfu && (stage.uop.cfu == `WB_CFU_JALI ||
                                   stage.uop.cfu == `WB_CFU_JALR);
    assign cfu_ebreak = fu_cfu && stage.uop.cfu == `WB_CFU_EBREAK;
    assign cfu_ecall  = fu_cfu && stage.uop.cfu == `WB_CFU_ECALL;
    assign cfu_mret   = fu_cfu && stage.uop.cfu == `WB_CFU_MRET;
    assign cfu_trap   = cfu_ebreak || cfu_ecall;

    assign cf_tgt_trap = cfu_trap || (s4_valid && stage.trap);
    assign cf_pending  = cfu_taken || cfu_mret || cf_tgt_trap;

    assign cf_req        = cf_pending && !cfu_done;     // Held until acked
    assign cf_finish_now = cf_req && cf_ack;

    always_comb begin
        if (cf_tgt_trap) begin
            cf_target = csr_mtvec;                      // Traps win over jumps
        end else if (cfu_mret) begin
            cf_target = csr_mepc;
        end else begin
            cf_target = stage.opr_a;                    // Branch or jump target
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cfu_done <= 1'b0;
        end else begin
            cfu_done <= !pipe_progress && (cfu_done || cf_finish_now);
        end
    end

    assign s4_busy = cf_pending && !(cfu_done || cf_finish_now);  // Drops on ack

    // ------------------------------------------------------------------------
    // GPR write and forwarding

    assign gpr_wr.rd  = stage.rd;
    assign gpr_wr.wen = !stage.trap &&
                        (fu_alu || fu_mul || load_wen || cfu_link || csr_gpr_wen);

    always_comb begin
        gpr_wr.wdata = stage.opr_a;                     // ALU, MUL and loads
        if (csr_gpr_wen) begin
            gpr_wr.wdata = csr_rdata;
        end else if (cfu_link) begin
            gpr_wr.wdata = stage.next_pc;               // Return address
        end
    end

    assign fwd_csr = fu_csr;

    // ------------------------------------------------------------------------
    // Trap report

    assign trap.valid = cf_tgt_trap && cf_finish_now;   // Only on the acked edge
    assign trap.cpu   = cfu_trap;
    assign trap.intr  = cf_tgt_trap && !cfu_trap;
    assign trap.pc    = stage.pc;

    always_comb begin
        if (cfu_ebreak) begin
            trap.cause = `WB_TRAP_BREAKPT;
        end else if (cfu_ecall) begin
            trap.cause = `WB_TRAP_ECALLM;
        end else begin
            trap.cause = stage.opr_a[5:0];              // External cause code
        end
    end

    // Trace, also flagged while ECALL, EBREAK or MRET wait for ack
    assign trace.valid = pipe_progress || cfu_trap || cfu_mret;
    assign trace.pc    = stage.pc;
    assign trace.instr = stage.instr;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the writeback stage regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_wb_top -f compile.f -o wb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/wb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    echo "PASS"
    exit 0
fi

echo "FAIL, see sim.log"
exit 1

// ==== tb/tb_wb_top.sv ====
/*
 * Writeback stage testbench
 * Plays the earlier stages and the fetch unit, drives random instructions
 */
`timescale 1ns/1ns
`include "wb_macros.svh"

module tb_wb_top;

    logic                   g_clk;
    logic                   g_resetn;
    wb_pkg::wb_stage_s      stage;
    logic                   s4_valid;
    logic                   s4_busy;
    logic                   cf_req;
    logic [`WB_XLEN-1:0]    cf_target;
    logic                   cf_ack;
    wb_pkg::wb_gpr_wr_s     fwd;
    logic                   fwd_csr;
    wb_pkg::wb_trace_s      trace;
    logic [4:0]             dbg_rs;
    logic [`WB_XLEN-1:0]    dbg_rdata;
    logic [31:0]            lfsr;           // Random state
    int                     check_errors;
    int                     timeouts;

    wb_top DUT (.*);

    wb_checker u_checker (.*, .errors(check_errors));

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;         // 40 ns period
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Present one instruction, acknowledge control flow, wait for retirement
    task automatic send(input logic [4:0] fu, input logic [4:0] uop, input logic [4:0] rd,
                        input logic [31:0] a, input logic [31:0] b, input logic trp,
                        input int ack_delay);
        int  n;
        int  wait_cnt;
        logic done;
        stage.rd      = rd;
        stage.opr_a   = a;
        stage.opr_b   = b;
        stage.pc      = {30'(rand_bits(30)), 2'b00};
        stage.next_pc = stage.pc + 32'd4;
        stage.uop.cfu = uop;
        stage.fu      = fu;
        stage.trap    = trp;
        stage.instr   = rand_bits(32);
        s4_valid      = 1'b1;
        dbg_rs        = 5'(rand_bits(5));
        n             = 0;
        wait_cnt      = ack_delay;
        done          = 1'b0;
        while (!done && n < 50) begin
            @(posedge g_clk);
            if (!s4_busy) done = 1'b1;      // Retires at this edge
            @(negedge g_clk);
            n++;
            dbg_rs = 5'(rand_bits(5));
            cf_ack = 1'b0;
            if (!done && cf_req) begin
                if (wait_cnt == 0) cf_ack = 1'b1;
                else wait_cnt--;
            end
        end
        cf_ack = 1'b0;
        if (!done) begin
            $display("Timeout: instruction at pc %h never retired", stage.pc);
            timeouts++;
        end
    endtask

    task automatic csr_op(input logic [11:0] addr, input logic [4:0] flags, input logic [31:0] v);
        send(5'b1 << `WB_FU_CSR, flags, 5'(rand_bits(5)), v, {20'h0, addr}, 1'b0, 0);
    endtask

    initial begin
        logic [2:0]  kind;
        logic [4:0]  flags;
        lfsr         = 32'h78ed;
        timeouts     = 0;
        g_resetn     = 1'b0;
        stage        = '0;
        s4_valid     = 1'b0;
        cf_ack       = 1'b0;
        dbg_rs       = 5'd0;
        repeat (8) @(negedge g_clk);
        g_resetn     = 1'b1;
        csr_op(`WB_CSR_MTVEC, 5'b00010, 32'h0000_0100);     // Trap vector first
        for (int i = 0; i < 300; i++) begin
            kind = 3'(rand_bits(3));
            case (kind)
                3'd0, 3'd1: send(5'b1 << rand_bits(1), '0, 5'(rand_bits(5)),
                                 rand_bits(32), '0, 1'b0, 0);          // ALU or MUL
                3'd2: send(5'b1 << `WB_FU_LSU, 5'(rand_bits(5)), 5'(rand_bits(5)),
                           rand_bits(32), '0, 1'b0, 0);                // Load or store
                3'd3: begin
                    flags = {3'b000, 1'(rand_bits(1)), 1'b0} << rand_bits(2);
                    flags = (flags == 5'd0 || flags[4]) ? 5'b00010 : flags;
                    flags[0] = 1'(rand_bits(1));                      // Read old value
                    csr_op(1'(rand_bits(1)) ? `WB_CSR_MSCRATCH : `WB_CSR_MTVEC, flags,
                           rand_bits(32));
                end
                3'd4: send(5'b1 << `WB_FU_CFU, 5'd1 + 5'(rand_bits(2) % 3), 5'(rand_bits(5)),
                           rand_bits(32), '0, 1'b0, int'(rand_bits(2)));
                3'd5: begin
                    send(5'b1 << `WB_FU_CFU, 1'(rand_bits(1)) ? `WB_CFU_ECALL : `WB_CFU_EBREAK,
                         5'(rand_bits(5)), rand_bits(32), '0, 1'b0, int'(rand_bits(2)));
                    csr_op(`WB_CSR_MCAUSE, 5'b00001, '0);
                    csr_op(`WB_CSR_MEPC, 5'b00001, '0);
                end
                3'd6: begin
                    send(5'b1 << `WB_FU_ALU, '0, 5'(rand_bits(5)), rand_bits(32), '0, 1'b1,
                         int'(rand_bits(2)));                         // External trap
                    csr_op(`WB_CSR_MEPC, 5'b00001, '0);
                    csr_op(`WB_CSR_MCAUSE, 5'b00001, '0);             // Interrupt bit and cause
                end
                default: send(5'b1 << `WB_FU_CFU, `WB_CFU_MRET, 5'd0, '0, '0, 1'b0,
                              int'(rand_bits(2)));
            endcase
        end
        // CSR set held over a stall by a trap on the same stage
        send(5'b1 << `WB_FU_CSR, 5'b00101, 5'd7, 32'h0000_00f0, {20'h0, `WB_CSR_MSCRATCH},
             1'b1, 2);
        csr_op(`WB_CSR_MSCRATCH, 5'b00001, '0);
        s4_valid = 1'b0;
        repeat (2) @(negedge g_clk);
        $display("Errors: checker %0d, timeouts %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== tb/wb_checker.sv ====
/*
 * Writeback checker
 * Reference model with shadow GPR and CSR state, compares DUT outputs
 */
`timescale 1ns/1ns
`include "wb_macros.svh"

module wb_checker (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_pkg::wb_stage_s       stage,
    input  logic                    s4_valid,
    input  logic                    s4_busy,
    input  logic                    cf_req,
    input  logic [`WB_XLEN-1:0]     cf_target,
    input  logic                    cf_ack,
    input  wb_pkg::wb_gpr_wr_s      fwd,
    input  logic                    fwd_csr,
    input  wb_pkg::wb_trace_s       trace,
    input  logic [4:0]              dbg_rs,
    input  logic [`WB_XLEN-1:0]     dbg_rdata,
    output int                      errors
);

    logic [31:0] gpr [0:31];                // Shadow registers
    logic [31:0] mscratch, mepc, mcause, mtvec;
    logic        in_flight, acked;          // Stage seen before, request acked
    logic        first, pend, cpu_trap, trap_tgt, exp_busy, do_cap, is_mret;
    logic [4:0]  code;
    logic [31:0] old, nval, exp_tgt;
    wb_pkg::wb_gpr_wr_s exp_wr;

    function automatic logic [31:0] csr_read(input logic [11:0] a);
        case (a)
            `WB_CSR_MSCRATCH: return mscratch;
            `WB_CSR_MEPC:     return mepc;
            `WB_CSR_MCAUSE:   return mcause;
            `WB_CSR_MTVEC:    return mtvec;
            default:          return '0;
        endcase
    endfunction

    // Expected GPR write for one stage cycle
    function automatic wb_pkg::wb_gpr_wr_s wb_model_step(input wb_pkg::wb_stage_s st,
                                                        input logic fst, input logic [31:0] co);
        wb_pkg::wb_gpr_wr_s w;
        w.rd    = st.rd;
        w.wdata = st.opr_a;
        w.wen   = st.fu[`WB_FU_ALU] || st.fu[`WB_FU_MUL] || (st.fu[`WB_FU_LSU] && st.uop.cfu[0]);
        if (st.fu[`WB_FU_CFU] && (st.uop.cfu == `WB_CFU_JALI || st.uop.cfu == `WB_CFU_JALR)) begin
            w.wen   = 1'b1;
            w.wdata = st.next_pc;           // Link address
        end
        if (st.fu[`WB_FU_CSR] && fst && st.uop.csr.read) begin
            w.wen   = 1'b1;
            w.wdata = co;
        end
        if (st.trap) w.wen = 1'b0;
        return w;
    endfunction

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        errors++;
    endtask

    initial errors = 0;

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < 32; i++) gpr[i] <= '0;
            {mscratch, mepc, mcause, mtvec} <= '0;
            in_flight <= 1'b0;
            acked     <= 1'b0;
        end else begin
            if (dbg_rdata !== gpr[dbg_rs]) report("dbg_read", gpr[dbg_rs], dbg_rdata);
            if (s4_valid) begin
                first    = !in_flight;
                code     = stage.uop.cfu;
                cpu_trap = stage.fu[`WB_FU_CFU] && (code == `WB_CFU_ECALL || code == `WB_CFU_EBREAK);
                is_mret  = stage.fu[`WB_FU_CFU] && code == `WB_CFU_MRET;
                trap_tgt = cpu_trap || stage.trap;
                pend     = trap_tgt || is_mret || (stage.fu[`WB_FU_CFU] &&
                           (code == `WB_CFU_TAKEN || code == `WB_CFU_JALI || code == `WB_CFU_JALR));
                exp_busy = pend && !acked && !cf_ack;
                exp_tgt  = trap_tgt ? mtvec : (is_mret ? mepc : stage.opr_a);
                old      = csr_read(stage.opr_b[11:0]);
                exp_wr   = wb_model_step(stage, first, old);
                if (s4_busy !== exp_busy) report("busy", 32'(exp_busy), 32'(s4_busy));
                if (cf_req !== (pend && !acked)) report("cf_req", 32'(pend && !acked), 32'(cf_req));
                if (cf_req && cf_target !== exp_tgt) report("cf_target", exp_tgt, cf_target);
                if (fwd.wen !== exp_wr.wen) report("gpr_wen", 32'(exp_wr.wen), 32'(fwd.wen));
                if (exp_wr.wen && fwd.rd !== exp_wr.rd) report("gpr_rd", 32'(exp_wr.rd), 32'(fwd.rd));
                if (exp_wr.wen && fwd.wdata !== exp_wr.wdata)
                    report("gpr_wdata", exp_wr.wdata, fwd.wdata);
                if (fwd_csr !== stage.fu[`WB_FU_CSR])
                    report("fwd_csr", 32'(stage.fu[`WB_FU_CSR]), 32'(fwd_csr));
                if (trace.valid !== (!exp_busy || cpu_trap || is_mret))
                    report("trace_valid", 32'(!exp_busy || cpu_trap || is_mret), 32'(trace.valid));
                if (trace.valid && trace.pc !== stage.pc) report("trace_pc", stage.pc, trace.pc);
                if (trace.valid && trace.instr !== stage.instr)
                    report("trace_instr", stage.instr, trace.instr);
                // Shadow state update
                if (exp_wr.wen && exp_wr.rd != 5'd0) gpr[exp_wr.rd] <= exp_wr.wdata;
                do_cap = trap_tgt && !acked && cf_ack;
                if (do_cap) begin
                    mepc   <= stage.pc;
                    mcause <= {!cpu_trap, 25'd0, cpu_trap ? (code == `WB_CFU_ECALL ?
                               `WB_TRAP_ECALLM : `WB_TRAP_BREAKPT) : stage.opr_a[5:0]};
                end else if (stage.fu[`WB_FU_CSR] && first &&
                             (stage.uop.csr.write || stage.uop.csr.set || stage.uop.csr.clr)) begin
                    nval = stage.uop.csr.write ? stage.opr_a :
                           (stage.uop.csr.set ? (old | stage.opr_a) : (old & ~stage.opr_a));
                    case (stage.opr_b[11:0])
                        `WB_CSR_MSCRATCH: mscratch <= nval;
                        `WB_CSR_MEPC:     mepc     <= nval;
                        `WB_CSR_MCAUSE:   mcause   <= nval;
                        `WB_CSR_MTVEC:    mtvec    <= nval;
                        default:          ;
                    endcase
                end
                in_flight <= exp_busy;
                acked     <= exp_busy && (acked || (pend && cf_ack));
            end else begin
                in_flight <= 1'b0;
                acked     <= 1'b0;
            end
        end
    end

endmodule
